// File: all.f
mul_arith_pkg.sv
mul_stream_pkg.sv
pipe_reg.sv
bw_partial_products.sv
csa_level.sv
wallace_tree.sv
wallace_mult_top.sv
tb_wallace_mult.sv

// File: bw_partial_products.sv
`timescale 1ns/1ps

module bw_partial_products (
    input  mul_stream_pkg::mul_req_t  req,
    output mul_arith_pkg::pp_matrix_t rows
);
    import mul_arith_pkg::*;

    localparam int MSB = OPERAND_W - 1;
    localparam int PAD_W = PRODUCT_W - OPERAND_W;

    for (genvar i = 0; i < OPERAND_W; i++) begin : g_row
        logic [OPERAND_W-1:0] and_bits;
        logic [OPERAND_W-1:0] bw_bits;
        logic [PRODUCT_W-1:0] ext_row;

        assign and_bits = req.a & {OPERAND_W{req.b[i]}};

        if (i < MSB) begin : g_plain
            // sign column of a is negated.
            assign bw_bits = {~and_bits[MSB], and_bits[MSB-1:0]};
        end else begin : g_sign
            // row of b's sign bit, all but the a7*b7 term negated.
            assign bw_bits = {and_bits[MSB], ~and_bits[MSB-1:0]};
        end

        assign ext_row = {{PAD_W{1'b0}}, bw_bits};

        // align to column i.
        assign rows[i] = ext_row << i;
    end

    assign rows[PP_ROWS-1] = BW_CORRECTION;

endmodule

// File: csa_level.sv
`timescale 1ns/1ps

module csa_level #(
    parameter int ROWS_IN = 3,
    localparam int ROWS_OUT = mul_arith_pkg::csa_rows(ROWS_IN)
) (
    input  mul_arith_pkg::product_t [ROWS_IN-1:0]  rows_in,
    output mul_arith_pkg::product_t [ROWS_OUT-1:0] rows_out
);
    import mul_arith_pkg::*;

    localparam int GROUPS = ROWS_IN / 3;
    localparam int LEFTOVER = ROWS_IN % 3;

    // full adders on every bit of three rows.
    for (genvar g = 0; g < GROUPS; g++) begin : g_group
        logic [PRODUCT_W-1:0] x;
        logic [PRODUCT_W-1:0] y;
        logic [PRODUCT_W-1:0] z;
        logic [PRODUCT_W-1:0] maj;

        assign x = rows_in[3*g];
        assign y = rows_in[3*g+1];
        assign z = rows_in[3*g+2];

        assign maj = (x & y) | (x & z) | (y & z);

        assign rows_out[2*g] = x ^ y ^ z;

        // carry weighs one column more, the top carry drops off.
        assign rows_out[2*g+1] = {maj[PRODUCT_W-2:0], 1'b0};
    end

    // rows outside a full group go on unchanged.
    for (genvar k = 0; k < LEFTOVER; k++) begin : g_pass
        assign rows_out[2*GROUPS+k] = rows_in[3*GROUPS+k];
    end

endmodule

// File: mul_arith_pkg.sv
package mul_arith_pkg;

    localparam int OPERAND_W = 8;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // eight shifted partial products plus the correction row.
    localparam int PP_ROWS = OPERAND_W + 1;

    // rows left after one level of 3:2 compressors.
    function automatic int csa_rows(input int rows_in);
        return 2 * (rows_in / 3) + rows_in % 3;
    endfunction

    // row counts through the tree: 9, 6, 4, 3, 2.
    localparam int L1_ROWS = csa_rows(PP_ROWS);
    localparam int MID_ROWS = csa_rows(L1_ROWS);
    localparam int L3_ROWS = csa_rows(MID_ROWS);
    localparam int L4_ROWS = csa_rows(L3_ROWS);

    // baugh-wooley correction ones at bits n and 2n-1.
    localparam logic [PRODUCT_W-1:0] BW_CORRECTION =
        (PRODUCT_W'(1) << OPERAND_W) | (PRODUCT_W'(1) << (PRODUCT_W - 1));

    typedef logic signed [OPERAND_W-1:0] operand_t;

    // full-width signed product, also one aligned row in the tree.
    typedef logic signed [PRODUCT_W-1:0] product_t;

    typedef product_t [PP_ROWS-1:0] pp_matrix_t;

    typedef product_t [MID_ROWS-1:0] mid_rows_t;

endpackage

// File: mul_stream_pkg.sv
package mul_stream_pkg;

    // one multiply request, a times b.
    typedef struct packed {
        mul_arith_pkg::operand_t a;
        mul_arith_pkg::operand_t b;
    } mul_req_t;

    // register stages along the path.
    localparam int IN_REG_STAGES = 1;
    localparam int TREE_STAGES = 1;
    localparam int OUT_REG_STAGES = 1;

    // cycles from an accepted strobe to out_valid.
    localparam int LATENCY = IN_REG_STAGES + TREE_STAGES + OUT_REG_STAGES;

endpackage

// File: pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  T     in_data,
    output logic out_valid,
    output T     out_data
);

    // valid is the only control state here.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload moves every cycle, no stall.
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the Wallace multiplier testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert -Wno-fatal \
    -f all.f \
    --top-module tb_wallace_mult \
    -o sim_wallace_mult

# The simulator exits nonzero on $fatal; the log decides the result.
./obj_dir/sim_wallace_mult 2>&1 | tee "$LOG" || true

if grep -qF '*** TEST FAILED ***' "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

if ! grep -qF '*** TEST PASSED ***' "$LOG"; then
    echo "simulation ended without a result, see $LOG"
    exit 1
fi

exit 0

// File: tb_wallace_mult.sv
`timescale 1ns/1ps

module tb_wallace_mult;
    import mul_arith_pkg::*;
    import mul_stream_pkg::*;

    localparam int RANDOM_PAIRS = 2000;
    localparam int BURST_LEN = 32;
    localparam int MAX_GAP = 3;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_TIMEOUT = 4 * LATENCY + 10;
    localparam int IDLE_TAIL = 8;

    // one outstanding result and the edge its strobe was driven on.
    typedef struct packed {
        product_t    product;
        logic [31:0] accept_cycle;
    } expect_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    mul_req_t in_req;
    logic     out_valid;
    product_t out_product;

    int      cycle = 0;
    int      in_flight;
    int      max_in_flight = 0;
    int      results_seen = 0;
    int      requests_sent = 0;
    expect_t expected_q[$];

    wallace_mult_top DUT (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_req      (in_req),
        .out_valid   (out_valid),
        .out_product (out_product)
    );

    always #5 clk = ~clk;

    // after rising edge k the counter holds k.
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("[ERROR] %0t %s", $time, what);
        stop_with_failure();
    endtask

    function automatic operand_t rand_operand();
        return operand_t'($urandom);
    endfunction

    // signed product of the operands, kept to the low 16 bits.
    function automatic product_t model_product(input operand_t a, input operand_t b);
        int full;
        full = int'(a) * int'(b);
        return product_t'(full);
    endfunction

    // strobe for one cycle, a following call keeps it high.
    task automatic send_req(input operand_t a, input operand_t b);
        @(posedge clk);
        in_valid <= 1'b1;
        in_req.a <= a;
        in_req.b <= b;
        requests_sent++;
    endtask

    // operands keep changing while idle and must be ignored.
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
            in_req.a <= rand_operand();
            in_req.b <= rand_operand();
        end
    endtask

    // scoreboard, sampled on the falling edge where everything is settled.
    always @(negedge clk) begin
        expect_t head;
        if (rst) begin
            assert (out_valid === 1'b0)
                else report_mismatch("out_valid", 32'd0, {31'd0, out_valid});
        end else begin
            assert (!$isunknown(out_valid))
                else report_problem("out_valid is unknown after reset");
            // requests held in the DUT registers, the one at the output included.
            in_flight = expected_q.size();
            if (in_flight > max_in_flight) begin
                max_in_flight = in_flight;
            end
            if (out_valid) begin
                assert (expected_q.size() > 0)
                    else report_problem("out_valid was high with no request outstanding");
                head = expected_q.pop_front();
                results_seen++;
                assert (out_product === head.product)
                    else report_mismatch("out_product", {16'd0, head.product},
                                         {16'd0, out_product});
                assert (cycle == head.accept_cycle + LATENCY)
                    else report_mismatch("latency", 32'(LATENCY),
                                         32'(cycle) - head.accept_cycle);
            end
            if (in_valid) begin
                head.product = model_product(in_req.a, in_req.b);
                head.accept_cycle = 32'(cycle);
                expected_q.push_back(head);
            end
        end
    end

    initial begin
        int gap;
        int waited;
        void'($urandom(32'ha66f3613));
        rst = 1'b1;
        in_valid = 1'b0;
        in_req = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // quiet pipeline after reset.
        idle_cycles(6);

        send_req(operand_t'(0), rand_operand());
        send_req(rand_operand(), operand_t'(0));
        send_req(operand_t'(0), operand_t'(-128));
        send_req(operand_t'(1), rand_operand());
        send_req(rand_operand(), operand_t'(1));
        send_req(operand_t'(1), operand_t'(-128));
        send_req(operand_t'(-1), operand_t'(-1));
        send_req(operand_t'(-1), operand_t'(-128));
        send_req(operand_t'(-128), operand_t'(-128));
        send_req(operand_t'(-128), operand_t'(127));
        send_req(operand_t'(127), operand_t'(-128));
        send_req(operand_t'(127), operand_t'(127));
        idle_cycles(LATENCY + 2);

        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            send_req(rand_operand(), rand_operand());
            gap = $urandom_range(MAX_GAP, 0);
            if (gap > 0) begin
                idle_cycles(gap);
            end
        end
        idle_cycles(LATENCY + 2);

        // strobes on every cycle fill all three stages.
        for (int i = 0; i < BURST_LEN; i++) begin
            send_req(rand_operand(), rand_operand());
        end
        idle_cycles(1);

        waited = 0;
        while (expected_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        assert (expected_q.size() == 0)
            else report_problem("results still outstanding after the drain timeout");

        idle_cycles(IDLE_TAIL);

        assert (max_in_flight == LATENCY)
            else report_mismatch("max_in_flight", 32'(LATENCY), 32'(max_in_flight));
        assert (results_seen == requests_sent)
            else report_mismatch("results_seen", 32'(requests_sent), 32'(results_seen));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: wallace_mult_top.sv
`timescale 1ns/1ps

module wallace_mult_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  mul_stream_pkg::mul_req_t in_req,
    output logic                     out_valid,
    output mul_arith_pkg::product_t  out_product
);
    import mul_arith_pkg::*;
    import mul_stream_pkg::*;

    logic       req_valid;
    mul_req_t   req_q;
    pp_matrix_t pp_rows;
    logic       tree_valid;
    product_t   tree_sum;

    // capture the strobe and operands.
    pipe_reg #(
        .T (mul_req_t)
    ) u_in_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_req),
        .out_valid (req_valid),
        .out_data  (req_q)
    );

    bw_partial_products u_pp_gen (
        .req  (req_q),
        .rows (pp_rows)
    );

    // one register inside the tree.
    wallace_tree u_tree (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .rows      (pp_rows),
        .out_valid (tree_valid),
        .sum       (tree_sum)
    );

    pipe_reg #(
        .T (product_t)
    ) u_out_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (tree_valid),
        .in_data   (tree_sum),
        .out_valid (out_valid),
        .out_data  (out_product)
    );

endmodule

// File: wallace_tree.sv
`timescale 1ns/1ps

module wallace_tree (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  mul_arith_pkg::pp_matrix_t rows,
    output logic                      out_valid,
    output mul_arith_pkg::product_t   sum
);
    import mul_arith_pkg::*;

    product_t [L1_ROWS-1:0] l1_rows;
    mid_rows_t              l2_rows;
    mid_rows_t              mid_q;
    logic                   mid_valid;
    product_t [L3_ROWS-1:0] l3_rows;
    product_t [L4_ROWS-1:0] l4_rows;

    // first half, 9 rows to 4.
    csa_level #(
        .ROWS_IN (PP_ROWS)
    ) u_level1 (
        .rows_in  (rows),
        .rows_out (l1_rows)
    );

    csa_level #(
        .ROWS_IN (L1_ROWS)
    ) u_level2 (
        .rows_in  (l1_rows),
        .rows_out (l2_rows)
    );

    // split point, two csa levels on each side.
    pipe_reg #(
        .T (mid_rows_t)
    ) u_mid_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (l2_rows),
        .out_valid (mid_valid),
        .out_data  (mid_q)
    );

    // second half, 4 rows to 2.
    csa_level #(
        .ROWS_IN (MID_ROWS)
    ) u_level3 (
        .rows_in  (mid_q),
        .rows_out (l3_rows)
    );

    csa_level #(
        .ROWS_IN (L3_ROWS)
    ) u_level4 (
        .rows_in  (l3_rows),
        .rows_out (l4_rows)
    );

    // carry-propagate add, carry out of bit 15 is dropped.
    assign sum = l4_rows[0] + l4_rows[1];

    assign out_valid = mid_valid;

endmodule
